/* source/spi_loop_pkg.sv */
package spi_loop_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    // one waveform sample, also one spi frame
    localparam int SAMPLE_W = 32;
    // host pipe word, two per sample
    localparam int PIPE_W = 16;
    // bits shifted per frame, msb first
    localparam int FRAME_BITS = SAMPLE_W;

    //////////////////////////////////////////////////
    // waveform storage
    //////////////////////////////////////////////////

    localparam int WAVE_DEPTH = 16;
    localparam int WAVE_ADDR_W = $clog2(WAVE_DEPTH);

    //////////////////////////////////////////////////
    // timing
    //////////////////////////////////////////////////

    // ep50trig cycles per sck half period, minus one
    localparam int SPI_CLKDIV = 13;
    // rate register width and its value out of reset
    localparam int HALF_CNT_W = 16;
    localparam int HALF_CNT_DEFAULT = 600;
    // tick counter holds up to 2 * (half_cnt + 1) - 1
    localparam int TICK_CNT_W = HALF_CNT_W + 1;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [PIPE_W-1:0] pipe_word_t;
    typedef logic [WAVE_ADDR_W-1:0] wave_addr_t;
    typedef logic [HALF_CNT_W-1:0] half_cnt_t;

endpackage

/* source/spi_link_if.sv */
interface spi_link_if;

    // serial clock, idles low (mode 0)
    logic sck;
    // master to slave data
    logic mosi;
    // frame select, active low
    logic ssel;
    // slave to master data
    logic miso;

    // master owns clock, data out and select
    modport master
    (
        output sck,
        output mosi,
        output ssel,
        input  miso
    );

    // slave only drives its return line
    modport slave
    (
        input  sck,
        input  mosi,
        input  ssel,
        output miso
    );

endinterface

/* source/sim_tick_gen.sv */
module sim_tick_gen
(
    input  logic                   ep50trig,
    input  logic                   reset_global,
    input  logic                   half_cnt_load,
    input  spi_loop_pkg::half_cnt_t half_cnt_data,
    output logic                   sim_tick
);

    import spi_loop_pkg::*;

    // programmed rate
    half_cnt_t rate_q;
    // cycles left until next tick
    logic [TICK_CNT_W-1:0] cnt;

    //////////////////////////////////////////////////
    // rate register and down-counter
    //////////////////////////////////////////////////

    // period is 2 * (rate + 1), so reload with 2 * rate + 1
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            rate_q   <= half_cnt_t'(HALF_CNT_DEFAULT);
            cnt      <= TICK_CNT_W'(2 * HALF_CNT_DEFAULT + 1);
            sim_tick <= 1'b0;
        end
        else if (half_cnt_load)
        begin
            // new rate restarts the period
            rate_q   <= half_cnt_data;
            cnt      <= {half_cnt_data, 1'b1};
            sim_tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt      <= {rate_q, 1'b1};
            sim_tick <= 1'b1;
        end
        else
        begin
            cnt      <= cnt - 1'b1;
            sim_tick <= 1'b0;
        end
    end

    // tick is a single-cycle strobe for the master
    a_tick_single : assert property (@(posedge ep50trig) disable iff (reset_global)
        sim_tick |=> !sim_tick);

endmodule

/* source/waveform_buffer.sv */
module waveform_buffer
(
    input  logic                    ep50trig,
    input  logic                    reset_global,
    input  logic                    repop,
    input  logic                    pipe_write,
    input  spi_loop_pkg::pipe_word_t pipe_data,
    input  logic                    take,
    output spi_loop_pkg::sample_t   sample,
    output logic                    sample_valid,
    output logic                    done_feeding
);

    import spi_loop_pkg::*;

    // sample storage
    sample_t mem [WAVE_DEPTH];
    // low half waiting for its partner
    pipe_word_t low_q;
    // next word is the high half
    logic hi_phase;
    // samples written so far with one bit more than the index
    logic [WAVE_ADDR_W:0] wr_cnt;
    // replay position
    wave_addr_t rd_idx;

    logic wr_low;
    logic wr_high;

    // writes stop once the buffer is full
    assign wr_low  = pipe_write && !done_feeding && !hi_phase;
    assign wr_high = pipe_write && !done_feeding && hi_phase;

    //////////////////////////////////////////////////
    // fill side
    //////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            hi_phase     <= 1'b0;
            wr_cnt       <= '0;
            done_feeding <= 1'b0;
        end
        else if (wr_low)
        begin
            hi_phase <= 1'b1;
        end
        else if (wr_high)
        begin
            hi_phase <= 1'b0;
            wr_cnt   <= wr_cnt + 1'b1;
            // last sample lands now and the flag follows a cycle later
            if (wr_cnt == WAVE_DEPTH - 1)
                done_feeding <= 1'b1;
        end
    end

    // low half holding register and sample memory
    always_ff @(posedge ep50trig)
    begin
        if (wr_low)
            low_q <= pipe_data;
        if (wr_high)
            mem[wr_cnt[WAVE_ADDR_W-1:0]] <= {pipe_data, low_q};
    end

    //////////////////////////////////////////////////
    // replay side
    //////////////////////////////////////////////////

    // repop rewinds but the data stays
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || repop)
            rd_idx <= '0;
        else if (take && done_feeding)
            // wraps mod WAVE_DEPTH
            rd_idx <= rd_idx + 1'b1;
    end

    assign sample_valid = done_feeding;
    // zero until every entry holds real data
    assign sample = done_feeding ? mem[rd_idx] : '0;

    a_wr_bound : assert property (@(posedge ep50trig) disable iff (reset_global)
        wr_cnt <= WAVE_DEPTH);

endmodule

/* source/spi_master.sv */
module spi_master
(
    input  logic                  ep50trig,
    input  logic                  reset_global,
    input  logic                  sim_tick,
    input  spi_loop_pkg::sample_t sample,
    input  logic                  sample_valid,
    output logic                  take,
    output logic                  frame_end,
    output spi_loop_pkg::sample_t master_out,
    spi_link_if.master            link
);

    import spi_loop_pkg::*;

    // frame in progress
    logic busy;
    logic start;
    // pin registers
    logic sck_q;
    logic mosi_q;
    logic ssel_q;
    // half-period and bit counters
    logic [$clog2(SPI_CLKDIV + 1)-1:0] div_cnt;
    logic [$clog2(FRAME_BITS)-1:0] bit_cnt;
    // shift registers
    sample_t tx_sh;
    sample_t rx_sh;

    logic half_done;
    logic sck_rise;
    logic sck_fall;

    // tick taken only when idle with a full buffer, else dropped
    assign start = sim_tick && !busy && sample_valid;
    assign take  = start;

    assign half_done = busy && (div_cnt == SPI_CLKDIV);
    // sck toggles at the end of every half period
    assign sck_rise = half_done && !sck_q;
    assign sck_fall = half_done && sck_q;

    //////////////////////////////////////////////////
    // frame control
    //////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            busy       <= 1'b0;
            sck_q      <= 1'b0;
            mosi_q     <= 1'b0;
            ssel_q     <= 1'b1;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            frame_end  <= 1'b0;
            master_out <= '0;
        end
        else
        begin
            frame_end <= 1'b0;
            if (start)
            begin
                // msb goes out before the first rising edge
                busy    <= 1'b1;
                ssel_q  <= 1'b0;
                sck_q   <= 1'b0;
                mosi_q  <= sample[FRAME_BITS-1];
                div_cnt <= '0;
                bit_cnt <= '0;
            end
            else if (busy)
            begin
                if (half_done)
                begin
                    div_cnt <= '0;
                    sck_q   <= !sck_q;
                end
                else
                begin
                    div_cnt <= div_cnt + 1'b1;
                end

                // data moves on the falling edge
                if (sck_fall)
                begin
                    if (bit_cnt == FRAME_BITS - 1)
                    begin
                        busy       <= 1'b0;
                        ssel_q     <= 1'b1;
                        mosi_q     <= 1'b0;
                        frame_end  <= 1'b1;
                        master_out <= rx_sh;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        mosi_q  <= tx_sh[FRAME_BITS-2];
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // shift registers
    //////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (start)
            tx_sh <= sample;
        else if (sck_fall)
            tx_sh <= {tx_sh[FRAME_BITS-2:0], 1'b0};
        // miso sampled on the rising edge
        if (sck_rise)
            rx_sh <= {rx_sh[FRAME_BITS-2:0], link.miso};
    end

    assign link.sck  = sck_q;
    assign link.mosi = mosi_q;
    assign link.ssel = ssel_q;

    // ssel moves only just after a start or at frame end
    a_ssel_frame : assert property (@(posedge ep50trig) disable iff (reset_global)
        $changed(ssel_q) |-> ($past(start) || frame_end));

    a_take_valid : assert property (@(posedge ep50trig) disable iff (reset_global)
        take |-> sample_valid);

endmodule

/* source/spi_slave.sv */
module spi_slave
(
    input  logic                  ep50trig,
    input  logic                  reset_global,
    output logic                  rdy,
    output spi_loop_pkg::sample_t slave_out,
    spi_link_if.slave             link
);

    import spi_loop_pkg::*;

    // registered copies for edge detection
    logic sck_d;
    logic ssel_d;
    // word received in the last frame, echoed in the next
    sample_t prev_word;
    sample_t rx_sh;
    sample_t tx_sh;
    logic miso_q;

    logic sck_rise;
    logic sck_fall;
    logic ssel_fall;
    logic ssel_rise;

    assign sck_rise  = link.sck && !sck_d;
    assign sck_fall  = !link.sck && sck_d;
    assign ssel_fall = !link.ssel && ssel_d;
    assign ssel_rise = link.ssel && !ssel_d;

    //////////////////////////////////////////////////
    // control and outputs
    //////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            sck_d     <= 1'b0;
            // starts deselected, so no false fall
            ssel_d    <= 1'b1;
            rdy       <= 1'b0;
            slave_out <= '0;
            prev_word <= '0;
            miso_q    <= 1'b0;
        end
        else
        begin
            sck_d  <= link.sck;
            ssel_d <= link.ssel;
            rdy    <= ssel_rise;
            if (ssel_rise)
            begin
                // frame complete, keep it for output and echo
                slave_out <= rx_sh;
                prev_word <= rx_sh;
                miso_q    <= 1'b0;
            end
            else if (ssel_fall)
            begin
                // msb valid before the first rising edge
                miso_q <= prev_word[FRAME_BITS-1];
            end
            else if (sck_fall && !link.ssel)
            begin
                miso_q <= tx_sh[FRAME_BITS-2];
            end
        end
    end

    //////////////////////////////////////////////////
    // shift registers
    //////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (ssel_fall)
            tx_sh <= prev_word;
        else if (sck_fall && !link.ssel)
            tx_sh <= {tx_sh[FRAME_BITS-2:0], 1'b0};
        // mosi taken on the rising edge
        if (sck_rise && !link.ssel)
            rx_sh <= {rx_sh[FRAME_BITS-2:0], link.mosi};
    end

    assign link.miso = miso_q;

endmodule

/* source/spi_loop_top.sv */
module spi_loop_top
(
    input  logic                    ep50trig,
    input  logic                    reset_global,
    input  logic                    reset_sim,
    input  logic                    pipe_write,
    input  spi_loop_pkg::pipe_word_t pipe_data,
    input  logic                    half_cnt_load,
    input  spi_loop_pkg::half_cnt_t  half_cnt_data,
    output logic                    done_feeding,
    output spi_loop_pkg::sample_t   wave_sample,
    output spi_loop_pkg::sample_t   master_out,
    output spi_loop_pkg::sample_t   slave_out,
    output logic                    frame_end,
    output logic                    slave_rdy,
    output logic                    sck,
    output logic                    mosi,
    output logic                    miso,
    output logic                    ssel
);

    // stage strobes
    logic sim_tick;
    logic sample_valid;
    logic take;

    // spi wires between master and slave
    spi_link_if link ();

    //////////////////////////////////////////////////
    // stages: tick, buffer, master, slave
    //////////////////////////////////////////////////

    sim_tick_gen u_tick
    (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .half_cnt_load (half_cnt_load),
        .half_cnt_data (half_cnt_data),
        .sim_tick      (sim_tick)
    );

    // reset_sim only rewinds replay
    waveform_buffer u_buf
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .repop        (reset_sim),
        .pipe_write   (pipe_write),
        .pipe_data    (pipe_data),
        .take         (take),
        .sample       (wave_sample),
        .sample_valid (sample_valid),
        .done_feeding (done_feeding)
    );

    spi_master u_master
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .sim_tick     (sim_tick),
        .sample       (wave_sample),
        .sample_valid (sample_valid),
        .take         (take),
        .frame_end    (frame_end),
        .master_out   (master_out),
        .link         (link.master)
    );

    spi_slave u_slave
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .rdy          (slave_rdy),
        .slave_out    (slave_out),
        .link         (link.slave)
    );

    // pins brought out for probing
    assign sck  = link.sck;
    assign mosi = link.mosi;
    assign miso = link.miso;
    assign ssel = link.ssel;

endmodule

/* dv/spi_loop_tb.sv */
module spi_loop_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import spi_loop_pkg::*;

    localparam int CLK_HALF = 5;
    localparam int TOTAL_FRAMES = 25;
    localparam int RATE_NEW = 500;
    // idle wait and fill plus every frame at the default tick period
    localparam int TICK_MAX = 2 * (HALF_CNT_DEFAULT + 1);
    localparam int TIMEOUT_NS = (1400 + (TOTAL_FRAMES + 2) * TICK_MAX) * 2 * CLK_HALF;

    // expected outputs around one frame end
    typedef struct packed
    {
        sample_t wave;
        sample_t slave;
        sample_t master;
    } expect_t;

    logic       ep50trig;
    logic       reset_global;
    logic       reset_sim;
    logic       pipe_write;
    pipe_word_t pipe_data;
    logic       half_cnt_load;
    half_cnt_t  half_cnt_data;
    logic       done_feeding;
    sample_t    wave_sample;
    sample_t    master_out;
    sample_t    slave_out;
    logic       frame_end;
    logic       slave_rdy;
    logic       sck;
    logic       mosi;
    logic       miso;
    logic       ssel;

    // model copy of the buffer contents as written
    sample_t     wave_mem [WAVE_DEPTH];
    logic [31:0] lfsr = 32'h4740_b9dd;
    int          cycle_cnt = 0;
    int          frames_done = 0;
    int          repop_base = 0;
    int          end_cycle [32];
    int          err_cnt = 0;
    int          test_err = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    string       cur_test = "none";
    // bits seen on the pins at each sck rise within a frame
    sample_t     mosi_cap;
    sample_t     miso_cap;
    logic        sck_seen = 1'b0;

    spi_loop_top u_dut
    (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .reset_sim     (reset_sim),
        .pipe_write    (pipe_write),
        .pipe_data     (pipe_data),
        .half_cnt_load (half_cnt_load),
        .half_cnt_data (half_cnt_data),
        .done_feeding  (done_feeding),
        .wave_sample   (wave_sample),
        .master_out    (master_out),
        .slave_out     (slave_out),
        .frame_end     (frame_end),
        .slave_rdy     (slave_rdy),
        .sck           (sck),
        .mosi          (mosi),
        .miso          (miso),
        .ssel          (ssel)
    );

    initial
    begin
        ep50trig = 1'b0;
        forever #CLK_HALF ep50trig = ~ep50trig;
    end

    always @(posedge ep50trig)
        cycle_cnt <= cycle_cnt + 1;

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit
    task automatic draw_sample(output sample_t w);
        int i;
        w = '0;
        for (i = 0; i < SAMPLE_W; i++)
        begin
            lfsr = lfsr_step(lfsr);
            w = {w[SAMPLE_W-2:0], lfsr[0]};
        end
    endtask

    // returns 1 ns after the edge that takes the word
    task automatic write_pipe(input pipe_word_t d);
        @(posedge ep50trig);
        #1;
        pipe_write = 1'b1;
        pipe_data  = d;
        @(posedge ep50trig);
        #1;
        pipe_write = 1'b0;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAIL %0s: %0s expected %h actual %h", cur_test, what, exp, act);
        err_cnt++;
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR %0s: %0s", cur_test, msg);
        err_cnt++;
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_err = err_cnt;
    endtask

    task automatic finish_test();
        tests_run++;
        if (err_cnt == test_err)
        begin
            $display("test %0s: ok", cur_test);
        end
        else
        begin
            tests_bad++;
            $display("test %0s: %0d errors", cur_test, err_cnt - test_err);
        end
    endtask

    //////////////////////////////////////////////////
    // reference model and compare
    //////////////////////////////////////////////////

    // n counts frames since the last repop and prev is the slave word of the frame before
    function automatic expect_t ref_frame(input int n, input sample_t prev);
        expect_t e;
        e.slave  = wave_mem[n % WAVE_DEPTH];
        // take already stepped the read index
        e.wave   = wave_mem[(n + 1) % WAVE_DEPTH];
        e.master = prev;
        return e;
    endfunction

    // serial pins sampled in the first cycle with sck high
    always @(negedge ep50trig)
    begin
        if (sck && !sck_seen && !ssel)
        begin
            mosi_cap <= {mosi_cap[SAMPLE_W-2:0], mosi};
            miso_cap <= {miso_cap[SAMPLE_W-2:0], miso};
        end
        sck_seen <= sck;
    end

    initial
    begin
        expect_t e;
        sample_t exp_prev;
        int      waited;
        exp_prev = '0;
        forever
        begin
            @(negedge ep50trig);
            if (frame_end)
            begin
                e = ref_frame(frames_done - repop_base, exp_prev);
                end_cycle[frames_done % 32] = cycle_cnt;
                if (master_out !== e.master)
                    report_mismatch("master_out", e.master, master_out);
                if (wave_sample !== e.wave)
                    report_mismatch("wave_sample", e.wave, wave_sample);
                // master sends this frame's sample, slave returns the last one
                if (mosi_cap !== e.slave)
                    report_mismatch("mosi bits", e.slave, mosi_cap);
                if (miso_cap !== e.master)
                    report_mismatch("miso bits", e.master, miso_cap);
                // slave sees ssel rise one cycle later
                waited = 0;
                @(negedge ep50trig);
                while (!slave_rdy && waited < 8)
                begin
                    @(negedge ep50trig);
                    waited++;
                end
                if (!slave_rdy)
                    report_problem("slave_rdy never followed frame_end");
                else if (slave_out !== e.slave)
                    report_mismatch("slave_out", e.slave, slave_out);
                @(negedge ep50trig);
                if (slave_rdy)
                    report_problem("slave_rdy stayed high for more than one cycle");
                exp_prev = e.slave;
                frames_done++;
            end
        end
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
        $display("sim failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial
    begin
        sample_t w;
        int      i;
        int      n_wr;
        reset_global  = 1'b1;
        reset_sim     = 1'b0;
        pipe_write    = 1'b0;
        pipe_data     = '0;
        half_cnt_load = 1'b0;
        half_cnt_data = '0;
        repeat (2) @(posedge ep50trig);
        #1;
        reset_global = 1'b0;

        // idle state and the default tick dropped while empty
        start_test("reset_state");
        @(negedge ep50trig);
        if (ssel !== 1'b1)
            report_mismatch("ssel", 1, ssel);
        if (sck !== 1'b0)
            report_mismatch("sck", 0, sck);
        if (mosi !== 1'b0)
            report_mismatch("mosi", 0, mosi);
        if (frame_end !== 1'b0 || slave_rdy !== 1'b0 || done_feeding !== 1'b0)
            report_problem("a strobe or flag is high after reset");
        if (master_out !== '0)
            report_mismatch("master_out", 0, master_out);
        if (slave_out !== '0)
            report_mismatch("slave_out", 0, slave_out);
        for (i = 0; i < TICK_MAX + 100; i++)
        begin
            @(negedge ep50trig);
            if (ssel !== 1'b1 || frame_end !== 1'b0)
                report_problem("a frame started before the buffer was full");
        end
        finish_test();

        start_test("filling");
        n_wr = 0;
        for (i = 0; i < WAVE_DEPTH; i++)
        begin
            draw_sample(w);
            wave_mem[i] = w;
            // low half first
            write_pipe(w[PIPE_W-1:0]);
            n_wr++;
            if (done_feeding !== 1'b0)
                report_mismatch("done_feeding early", 0, done_feeding);
            write_pipe(w[SAMPLE_W-1:PIPE_W]);
            n_wr++;
            if (n_wr < 2 * WAVE_DEPTH && done_feeding !== 1'b0)
                report_mismatch("done_feeding early", 0, done_feeding);
        end
        if (done_feeding !== 1'b1)
            report_mismatch("done_feeding after last write", 1, done_feeding);
        if (wave_sample !== wave_mem[0])
            report_mismatch("wave_sample after fill", wave_mem[0], wave_sample);
        // extra writes must be ignored and loopback would show any damage
        for (i = 0; i < 2; i++)
        begin
            draw_sample(w);
            write_pipe(w[PIPE_W-1:0]);
            write_pipe(w[SAMPLE_W-1:PIPE_W]);
        end
        finish_test();

        start_test("loopback");
        wait (frames_done == WAVE_DEPTH);
        finish_test();

        start_test("wrap");
        wait (frames_done == WAVE_DEPTH + 4);
        finish_test();

        // load between frames while the master is idle
        start_test("rate");
        @(posedge ep50trig);
        #1;
        half_cnt_load = 1'b1;
        half_cnt_data = half_cnt_t'(RATE_NEW);
        @(posedge ep50trig);
        #1;
        half_cnt_load = 1'b0;
        wait (frames_done == WAVE_DEPTH + 7);
        for (i = WAVE_DEPTH + 5; i < WAVE_DEPTH + 7; i++)
        begin
            if (end_cycle[i] - end_cycle[i - 1] != 2 * (RATE_NEW + 1))
                report_mismatch("frame_end spacing", 2 * (RATE_NEW + 1),
                                end_cycle[i] - end_cycle[i - 1]);
        end
        finish_test();

        start_test("repop");
        @(posedge ep50trig);
        #1;
        reset_sim  = 1'b1;
        repop_base = frames_done;
        @(posedge ep50trig);
        #1;
        reset_sim = 1'b0;
        wait (frames_done == TOTAL_FRAMES);
        finish_test();

        $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_bad, err_cnt);
        if (err_cnt == 0 && tests_bad == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* files.f */
source/spi_loop_pkg.sv
source/spi_link_if.sv
source/sim_tick_gen.sv
source/waveform_buffer.sv
source/spi_master.sv
source/spi_slave.sv
source/spi_loop_top.sv
dv/spi_loop_tb.sv
